// ==== Makefile ====
TOP := tb_ulpi_link

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim.f ====
+incdir+verilog
verilog/ulpi_pkg.sv
verilog/usb_beat_fifo.sv
verilog/ulpi_link_tx.sv
verilog/ulpi_link_rx.sv
verilog/fake_ulpi_phy.sv
verilog/ulpi_link_top.sv
tests/clock_gen.sv
tests/tb_ulpi_link.sv

// ==== tests/clock_gen.sv ====
`default_nettype none

module clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic clock_o,
  output logic reset_o
);

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD / 2) clock_o = ~clock_o;
  end

  // Reset drops on a falling edge, away from the rising edges the DUT samples on
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tests/tb_ulpi_link.sv ====
`default_nettype none

`include "ulpi_cfg.svh"

module tb_ulpi_link
  import ulpi_pkg::*;
();

  localparam int PERIOD     = 40;
  localparam int MAX_LEN    = 12;
  localparam int ITERATIONS = 40;
  localparam int LINE_WAIT  = 32;
  // Directed packets and line changes come on top of the random iterations
  localparam int NUM_OPS    = ITERATIONS + 8;
  // Worst case moves one receive and one transmit packet through both turnarounds
  localparam int OP_CYCLES  = 2 * MAX_LEN + `ULPI_TURN_WAIT + 24;
  localparam int BUDGET     = (NUM_OPS * OP_CYCLES + 100) * PERIOD;

  logic        clock;
  logic        reset;
  logic        host_tx_stb;
  usb_beat_t   host_tx;
  logic        host_rx_stb;
  usb_beat_t   host_rx;
  line_state_t line_state;
  logic        usb_rx_stb;
  usb_beat_t   usb_rx;
  line_state_t line_state_in;
  logic        usb_tx_stb;
  usb_beat_t   usb_tx;

  // Reference model holds the expected beats per direction in arrival order
  usb_beat_t   tx_expect[$];
  usb_beat_t   rx_expect[$];
  int          tx_packets = 0;
  int          rx_packets = 0;
  int          tx_read    = 0;
  int          rx_read    = 0;
  int          tx_done    = 0;
  int          rx_done    = 0;
  int          tx_errors  = 0;
  int          rx_errors  = 0;
  int          errors     = 0;
  logic [31:0] lcg_state;

  clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(5)) u_clock_gen (
    .clock_o(clock),
    .reset_o(reset)
  );

  ulpi_link_top UUT (
    .clock        (clock),
    .reset        (reset),
    .host_tx_stb_i(host_tx_stb),
    .host_tx_i    (host_tx),
    .host_rx_stb_o(host_rx_stb),
    .host_rx_o    (host_rx),
    .line_state_o (line_state),
    .usb_rx_stb_i (usb_rx_stb),
    .usb_rx_i     (usb_rx),
    .line_state_i (line_state_in),
    .usb_tx_stb_o (usb_tx_stb),
    .usb_tx_o     (usb_tx)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int bound);
    logic [31:0] r;
    r = lcg_next();
    return int'(r[31:8] % bound);
  endfunction

  function automatic int rand_len();
    return 1 + rand_below(MAX_LEN);
  endfunction

  // Any line state other than the one last driven
  function automatic line_state_t pick_line_state();
    return line_state_t'(2'(line_state_in) + 2'(1 + rand_below(3)));
  endfunction

  function automatic int beat_mismatch(input string name, input usb_beat_t expected,
                                       input usb_beat_t actual);
    int bad;
    bad = 0;
    assert (actual == expected) else begin
      $display("[ERROR] %s: expected data %h last %0d, actual data %h last %0d",
               name, expected.data, expected.last, actual.data, actual.last);
      bad = 1;
    end
    return bad;
  endfunction

  // Host and USB-side bytes go in together with one strobe per cycle
  task automatic drive_packets(input int tx_len, input int rx_len);
    usb_beat_t  beat;
    logic [3:0] pid;
    pid = 4'(rand_below(16));
    for (int i = 0; i < tx_len || i < rx_len; i++) begin
      host_tx_stb = i < tx_len;
      usb_rx_stb  = i < rx_len;
      if (i < tx_len) begin
        beat.data = (i == 0) ? {~pid, pid} : 8'(rand_below(256));
        beat.last = i == tx_len - 1;
        host_tx   = beat;
        tx_expect.push_back(beat);
      end
      if (i < rx_len) begin
        beat.data = 8'(rand_below(256));
        beat.last = i == rx_len - 1;
        usb_rx    = beat;
        rx_expect.push_back(beat);
      end
      @(negedge clock);
    end
    host_tx_stb = 1'b0;
    usb_rx_stb  = 1'b0;
    if (tx_len > 0) begin
      tx_packets++;
    end
    if (rx_len > 0) begin
      rx_packets++;
    end
  endtask

  task automatic wait_drained();
    while (tx_done < tx_packets || rx_done < rx_packets) begin
      @(negedge clock);
    end
  endtask

  task automatic change_line_state(input line_state_t state_new);
    int waited;
    line_state_in = state_new;
    waited = 0;
    while (line_state != state_new && waited < LINE_WAIT) begin
      @(negedge clock);
      waited++;
    end
    assert (line_state == state_new) else begin
      errors++;
      $display("[ERROR] line_state: expected %s, actual %s",
               state_new.name(), line_state.name());
    end
  endtask

  always @(posedge clock) begin : tx_monitor
    logic first;
    if (!reset && usb_tx_stb) begin
      assert (tx_read < tx_expect.size()) else begin
        tx_errors++;
        $display("usb_tx strobed byte %h that no host packet accounts for", usb_tx.data);
      end
      if (tx_read < tx_expect.size()) begin
        first = tx_read == 0 || tx_expect[tx_read - 1].last;
        if (first) begin
          tx_errors += beat_mismatch("tx_pid", tx_expect[tx_read], usb_tx);
        end else begin
          tx_errors += beat_mismatch("tx_data", tx_expect[tx_read], usb_tx);
        end
        if (tx_expect[tx_read].last) begin
          tx_done++;
        end
        tx_read++;
      end
    end
  end

  always @(posedge clock) begin : rx_monitor
    if (!reset && host_rx_stb) begin
      assert (rx_read < rx_expect.size()) else begin
        rx_errors++;
        $display("host_rx delivered byte %h that no USB packet accounts for", host_rx.data);
      end
      if (rx_read < rx_expect.size()) begin
        rx_errors += beat_mismatch("rx_data", rx_expect[rx_read], host_rx);
        if (rx_expect[rx_read].last) begin
          rx_done++;
        end
        rx_read++;
      end
    end
  end

  initial begin : watchdog
    #(BUDGET);
    $display("Watchdog expired after %0d time units with traffic still pending", BUDGET);
    $display("Verification failed");
    $finish;
  end

  initial begin : main_sequence
    int kind;
    lcg_state     = 32'hc59ae2b7;
    host_tx_stb   = 1'b0;
    host_tx       = '0;
    usb_rx_stb    = 1'b0;
    usb_rx        = '0;
    line_state_in = LS_J;
    @(negedge reset);
    @(negedge clock);
    assert (line_state == LS_J) else begin
      errors++;
      $display("[ERROR] reset_line_state: expected LS_J, actual %s", line_state.name());
    end
    assert (!usb_tx_stb && !host_rx_stb) else begin
      errors++;
      $display("A strobe is high right after reset");
    end

    // Directed transmit, a PID-only packet and a receive
    drive_packets(rand_len(), 0);
    wait_drained();
    drive_packets(1, 0);
    wait_drained();
    drive_packets(0, rand_len());
    wait_drained();

    // Three line-state changes in a row
    repeat (3) begin
      change_line_state(pick_line_state());
    end

    for (int iter = 0; iter < ITERATIONS; iter++) begin
      kind = rand_below(4);
      case (kind)
        0:       drive_packets(rand_len(), 0);
        1:       drive_packets(0, rand_len());
        2:       change_line_state(pick_line_state());
        default: drive_packets(rand_len(), rand_len());
      endcase
      wait_drained();
    end

    // Quiet tail so a stray beat still shows up
    repeat (10) @(negedge clock);
    assert (tx_read == tx_expect.size()) else begin
      errors++;
      $display("usb_tx delivered %0d of %0d expected beats", tx_read, tx_expect.size());
    end
    assert (rx_read == rx_expect.size()) else begin
      errors++;
      $display("host_rx delivered %0d of %0d expected beats", rx_read, rx_expect.size());
    end

    $display("Errors: transmit %0d, receive %0d, other %0d", tx_errors, rx_errors, errors);
    if (tx_errors + rx_errors + errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/fake_ulpi_phy.sv ====
`default_nettype none

`include "ulpi_cfg.svh"

module fake_ulpi_phy
  import ulpi_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  ulpi_link_bus_t link_i,
  output ulpi_phy_bus_t  phy_o,
  input  wire            usb_rx_stb_i,
  input  usb_beat_t      usb_rx_i,
  input  line_state_t    line_state_i,
  output logic           usb_tx_stb_o,
  output usb_beat_t      usb_tx_o
);

  // ID high, no RxEvent, VBUS valid, line state appended below
  localparam logic [5:0] RX_CMD_TOP = 6'b01_00_11;
  localparam logic [3:0] TURN_WAIT  = 4'(`ULPI_TURN_WAIT);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT,
    ST_SEND,
    ST_RECV,
    ST_LINE,
    ST_STAT
  } phy_state_t;

  phy_state_t  state;
  logic        dir_q;
  logic        nxt_q;
  logic [7:0]  data_q;
  logic        send_last_q;
  logic        first_q;
  logic        tx_stb_q;
  logic [7:0]  tx_data_q;
  line_state_t reported_q;
  logic [3:0]  idle_cnt;

  usb_beat_t   rx_head;
  logic        rx_empty;
  logic        rx_pop;
  logic        link_busy;
  logic        bus_idle;
  logic        start_recv;
  logic        start_send;
  logic        start_line;
  logic        take;

  // Receive-side buffer fed by the USB side
  usb_beat_fifo u_rx_fifo (
    .clock    (clock),
    .reset    (reset),
    .wr_stb_i (usb_rx_stb_i),
    .wr_beat_i(usb_rx_i),
    .pop_i    (rx_pop),
    .head_o   (rx_head),
    .empty_o  (rx_empty)
  );

  assign phy_o = '{data: data_q, dir: dir_q, nxt: nxt_q};

  assign link_busy = link_i.data != 8'h00 || link_i.stp;
  assign bus_idle  = idle_cnt == TURN_WAIT && !link_busy;

  // Link transmit wins, then a buffered packet, then a line-state report
  assign start_recv = state == ST_IDLE && link_i.data != 8'h00;
  assign start_send = state == ST_IDLE && bus_idle && !rx_empty;
  assign start_line = state == ST_IDLE && bus_idle && rx_empty && line_state_i != reported_q;

  assign take   = state == ST_RECV && nxt_q && !link_i.stp;
  assign rx_pop = state == ST_WAIT || (state == ST_SEND && !send_last_q);

  // The PID strobe comes from the TX CMD and stp marks the byte strobed with it
  assign usb_tx_stb_o = tx_stb_q;
  assign usb_tx_o     = '{data: tx_data_q, last: link_i.stp};

  // Count consecutive cycles of an idle link bus
  always_ff @(posedge clock) begin
    if (reset || dir_q || link_busy) begin
      idle_cnt <= '0;
    end else if (idle_cnt != TURN_WAIT) begin
      idle_cnt <= idle_cnt + 4'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ST_IDLE;
      dir_q      <= 1'b0;
      nxt_q      <= 1'b0;
      first_q    <= 1'b0;
      tx_stb_q   <= 1'b0;
      reported_q <= LS_J;
    end else begin
      tx_stb_q <= take;
      case (state)
        ST_IDLE: begin
          if (start_recv) begin
            state   <= ST_RECV;
            nxt_q   <= 1'b1;
            first_q <= 1'b1;
          end else if (start_send) begin
            state <= ST_WAIT;
            dir_q <= 1'b1;
          end else if (start_line) begin
            state      <= ST_LINE;
            dir_q      <= 1'b1;
            reported_q <= line_state_i;
          end
        end
        ST_WAIT: begin
          // Data flows once the turnaround cycle is over
          state <= ST_SEND;
          nxt_q <= 1'b1;
        end
        ST_SEND: begin
          if (send_last_q) begin
            state <= ST_IDLE;
            dir_q <= 1'b0;
            nxt_q <= 1'b0;
          end
        end
        ST_RECV: begin
          if (take) begin
            first_q <= 1'b0;
          end
          if (link_i.stp) begin
            state <= ST_IDLE;
            nxt_q <= 1'b0;
          end
        end
        ST_LINE: begin
          state <= ST_STAT;
        end
        default: begin
          state <= ST_IDLE;
          dir_q <= 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      tx_data_q <= first_q ? {~link_i.data[3:0], link_i.data[3:0]} : link_i.data;
    end
    case (state)
      ST_WAIT, ST_SEND: begin
        data_q      <= rx_pop ? rx_head.data : 8'h00;
        send_last_q <= rx_head.last;
      end
      ST_LINE: begin
        data_q <= {RX_CMD_TOP, reported_q};
      end
      default: begin
        data_q <= 8'h00;
      end
    endcase
  end

  // Turnaround cycles carry nothing, so nxt must stay low across a dir change
  a_no_nxt_on_turn: assert property (
    @(posedge clock) disable iff (reset) (phy_o.dir != $past(phy_o.dir)) |-> !phy_o.nxt)
    else $error("nxt high during a turnaround cycle");

endmodule

`default_nettype wire

// ==== verilog/ulpi_cfg.svh ====
`ifndef ULPI_CFG_SVH
`define ULPI_CFG_SVH

// Sizes and timing constants of the ULPI link and the PHY model

// Beats held by each packet FIFO
// One full packet of up to 12 beats fits with room to spare
`define ULPI_FIFO_DEPTH 16

// Idle cycles of zero link data the PHY needs before it raises dir
`define ULPI_TURN_WAIT 2

`endif

// ==== verilog/ulpi_link_rx.sv ====
`default_nettype none

module ulpi_link_rx
  import ulpi_pkg::*;
(
  input  wire           clock,
  input  wire           reset,
  input  ulpi_phy_bus_t phy_i,
  output logic          host_rx_stb_o,
  output usb_beat_t     host_rx_o,
  output line_state_t   line_state_o
);

  logic       dir_q;
  logic       hold_valid_q;
  logic [7:0] hold_q;
  logic       data_cycle;
  logic       cmd_cycle;
  logic       dir_fell;

  // The first cycle with dir high is turnaround and matches neither case
  assign data_cycle = phy_i.dir && dir_q && phy_i.nxt;
  assign cmd_cycle  = phy_i.dir && dir_q && !phy_i.nxt;
  assign dir_fell   = !phy_i.dir && dir_q;

  // Held byte goes out when the next one arrives, or as last when dir drops
  assign host_rx_stb_o = hold_valid_q && (data_cycle || dir_fell);
  assign host_rx_o     = '{data: hold_q, last: dir_fell};

  always_ff @(posedge clock) begin
    if (reset) begin
      dir_q        <= 1'b0;
      hold_valid_q <= 1'b0;
      line_state_o <= LS_J;
    end else begin
      dir_q <= phy_i.dir;
      if (data_cycle) begin
        hold_valid_q <= 1'b1;
      end else if (dir_fell) begin
        hold_valid_q <= 1'b0;
      end
      // Line state of an RX CMD sits in the low two bits
      if (cmd_cycle) begin
        line_state_o <= line_state_t'(phy_i.data[1:0]);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (data_cycle) begin
      hold_q <= phy_i.data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ulpi_link_top.sv ====
`default_nettype none

module ulpi_link_top
  import ulpi_pkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  wire         host_tx_stb_i,
  input  usb_beat_t   host_tx_i,
  output logic        host_rx_stb_o,
  output usb_beat_t   host_rx_o,
  output line_state_t line_state_o,
  input  wire         usb_rx_stb_i,
  input  usb_beat_t   usb_rx_i,
  input  line_state_t line_state_i,
  output logic        usb_tx_stb_o,
  output usb_beat_t   usb_tx_o
);

  usb_beat_t      tx_head;
  logic           tx_empty;
  logic           tx_pop;
  ulpi_link_bus_t link_bus;
  ulpi_phy_bus_t  phy_bus;

  // Host bytes wait here until the transmitter gets the bus
  usb_beat_fifo u_tx_fifo (
    .clock    (clock),
    .reset    (reset),
    .wr_stb_i (host_tx_stb_i),
    .wr_beat_i(host_tx_i),
    .pop_i    (tx_pop),
    .head_o   (tx_head),
    .empty_o  (tx_empty)
  );

  ulpi_link_tx u_link_tx (
    .clock  (clock),
    .reset  (reset),
    .head_i (tx_head),
    .empty_i(tx_empty),
    .pop_o  (tx_pop),
    .phy_i  (phy_bus),
    .link_o (link_bus)
  );

  ulpi_link_rx u_link_rx (
    .clock        (clock),
    .reset        (reset),
    .phy_i        (phy_bus),
    .host_rx_stb_o(host_rx_stb_o),
    .host_rx_o    (host_rx_o),
    .line_state_o (line_state_o)
  );

  fake_ulpi_phy u_phy (
    .clock       (clock),
    .reset       (reset),
    .link_i      (link_bus),
    .phy_o       (phy_bus),
    .usb_rx_stb_i(usb_rx_stb_i),
    .usb_rx_i    (usb_rx_i),
    .line_state_i(line_state_i),
    .usb_tx_stb_o(usb_tx_stb_o),
    .usb_tx_o    (usb_tx_o)
  );

endmodule

`default_nettype wire

// ==== verilog/ulpi_link_tx.sv ====
`default_nettype none

module ulpi_link_tx
  import ulpi_pkg::*;
(
  input  wire            clock,
  input  wire            reset,
  input  usb_beat_t      head_i,
  input  wire            empty_i,
  output logic           pop_o,
  input  ulpi_phy_bus_t  phy_i,
  output ulpi_link_bus_t link_o
);

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_CMD,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  tx_state_t state;
  logic      taken;

  // A byte only counts as taken while the link owns the bus
  assign taken = phy_i.nxt && !phy_i.dir;

  // The PID beat is consumed by the TX CMD itself
  assign pop_o = taken && (state == TX_CMD || state == TX_DATA);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= TX_IDLE;
    end else begin
      case (state)
        TX_IDLE: begin
          if (!phy_i.dir && !empty_i) begin
            state <= TX_CMD;
          end
        end
        TX_CMD: begin
          // Back off and retry when the PHY grabs the bus before the command is taken
          if (phy_i.dir) begin
            state <= TX_IDLE;
          end else if (taken) begin
            state <= head_i.last ? TX_STOP : TX_DATA;
          end
        end
        TX_DATA: begin
          if (taken && head_i.last) begin
            state <= TX_STOP;
          end
        end
        default: begin
          state <= TX_IDLE;
        end
      endcase
    end
  end

  always_comb begin
    link_o = '0;
    case (state)
      TX_CMD: begin
        // TX CMD carries transmit type 4 above the PID nibble
        if (!phy_i.dir) begin
          link_o.data = {4'h4, head_i.data[3:0]};
        end
      end
      TX_DATA: begin
        link_o.data = head_i.data;
      end
      TX_STOP: begin
        link_o.stp = 1'b1;
      end
      default: begin
        link_o = '0;
      end
    endcase
  end

  // stp with dir high would abort a PHY receive
  a_stp_only_when_owner: assert property (
    @(posedge clock) disable iff (reset) $rose(link_o.stp) |-> !phy_i.dir)
    else $error("stp raised while the PHY owns the bus");

endmodule

`default_nettype wire

// ==== verilog/ulpi_pkg.sv ====
`default_nettype none

package ulpi_pkg;

  // One byte of a USB packet with a flag on its final byte
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } usb_beat_t;

  // Signals the link drives onto ULPI
  typedef struct packed {
    logic [7:0] data;
    logic       stp;
  } ulpi_link_bus_t;

  // Signals the PHY drives onto ULPI
  typedef struct packed {
    logic [7:0] data;
    logic       dir;
    logic       nxt;
  } ulpi_phy_bus_t;

  // USB line state as carried in RX CMD bits 1:0
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,
    LS_J   = 2'b01,
    LS_K   = 2'b10,
    LS_SE1 = 2'b11
  } line_state_t;

endpackage

`default_nettype wire

// ==== verilog/usb_beat_fifo.sv ====
`default_nettype none

`include "ulpi_cfg.svh"

module usb_beat_fifo
  import ulpi_pkg::*;
(
  input  wire       clock,
  input  wire       reset,
  input  wire       wr_stb_i,
  input  usb_beat_t wr_beat_i,
  input  wire       pop_i,
  output usb_beat_t head_o,
  output logic      empty_o
);

  localparam int DEPTH = `ULPI_FIFO_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  usb_beat_t        mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  assign full    = count == (PTR_W + 1)'(DEPTH);
  assign empty_o = count == '0;

  // Head is read straight from the array and shows the cycle after its write
  assign head_o = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (wr_stb_i) begin
      mem[wr_ptr] <= wr_beat_i;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_stb_i) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_i) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_stb_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producers have no back-pressure, so a write into a full FIFO loses a beat
  a_no_overflow: assert property (@(posedge clock) disable iff (reset) wr_stb_i |-> !full)
    else $error("usb_beat_fifo written while full");

  // The consumer may only take a beat that has arrived
  a_no_underflow: assert property (@(posedge clock) disable iff (reset) pop_i |-> !empty_o)
    else $error("usb_beat_fifo popped while empty");

endmodule

`default_nettype wire
